/* Makefile */
TOP = alu8_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module alu8_top
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

/* logic/alu8_top.sv */
`timescale 1ns/1ps

module alu8_top #(
    parameter int SLICE_W = alu_pkg::SLICE_W_DEF
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       in_valid,
    input  alu_pkg::alu_ctrl_u         op,
    input  logic                       carry_in,
    input  logic [alu_pkg::DATA_W-1:0] a,
    input  logic [alu_pkg::DATA_W-1:0] b,
    output logic                       out_valid,
    output logic [alu_pkg::DATA_W-1:0] result,
    output logic                       carry_out,
    output logic                       zero,
    output logic                       equal
);

    import alu_pkg::*;

    localparam int HI_W = DATA_W - SLICE_W;

    logic [DATA_W-1:0] a_q;
    logic [DATA_W-1:0] b_q;
    alu_ctrl_t         ctrl_d;
    alu_ctrl_t         ctrl_q;
    logic              valid_q;

    slice_result_if #(.SLICE_W(SLICE_W)) low_r ();
    slice_result_if #(.SLICE_W(HI_W))    hi0_r ();
    slice_result_if #(.SLICE_W(HI_W))    hi1_r ();

    always_comb begin
        ctrl_d          = op.ctrl;
        ctrl_d.carry_in = carry_in;  // the carry_in port wins over the command bit
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_q     <= '0;
            b_q     <= '0;
            ctrl_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
            if (in_valid) begin
                a_q    <= a;
                b_q    <= b;
                ctrl_q <= ctrl_d;
            end
        end
    end

    alu_slice #(.SLICE_W(SLICE_W)) u_low (
        .a        (a_q[SLICE_W-1:0]),
        .b        (b_q[SLICE_W-1:0]),
        .ctrl     (ctrl_q),
        .carry_in (ctrl_q.carry_in),
        .shift_in (b_q[SLICE_W] ^ ctrl_q.b_inv),  // lowest effective bit of the high half
        .r        (low_r)
    );

    carry_select_pair #(.SLICE_W(HI_W)) u_high (
        .a        (a_q[DATA_W-1:SLICE_W]),
        .b        (b_q[DATA_W-1:SLICE_W]),
        .ctrl     (ctrl_q),
        .shift_in (ctrl_q.carry_in),  // fill for bit 7 on RSHFT
        .r0       (hi0_r),
        .r1       (hi1_r)
    );

    result_merge #(.SLICE_W(SLICE_W)) u_merge (
        .clk           (clk),
        .arst_n        (arst_n),
        .valid         (valid_q),
        .carry_disable (ctrl_q.carry_disable),
        .low           (low_r),
        .hi0           (hi0_r),
        .hi1           (hi1_r),
        .out_valid     (out_valid),
        .result        (result),
        .carry_out     (carry_out),
        .zero          (zero),
        .equal         (equal)
    );

endmodule

/* logic/alu_pkg.sv */
package alu_pkg;

    localparam int DATA_W      = 8;  // operand and result width
    localparam int SLICE_W_DEF = 4;  // width of one carry-lookahead slice

    // command codes, bit order matches alu_ctrl_t below
    // fields: carry_in, b_inv, carry_disable, mux_sel[1:0]
    typedef enum logic [4:0] {
        ADD   = 5'b00000,  // also a left shift when a equals b
        SUB   = 5'b11000,  // a + ~b + 1, carry out set when a >= b
        XOR   = 5'b00100,  // half-sum with the carry gated off
        XNOR  = 5'b01100,  // gives NOT b when a is 0
        COMP  = 5'b01000,  // a - b - 1, all ones when a == b
        AND   = 5'b00101,
        OR    = 5'b00110,
        RSHFT = 5'b00111   // operand b moves one bit right, a is ignored
    } alu_cmd_e;

    // per-bit control as seen by the bit cells
    typedef struct packed {
        logic       carry_in;       // carry into bit 0, also the shift fill
        logic       b_inv;          // use ~b instead of b
        logic       carry_disable;  // keeps the carry out of logic results
        logic [1:0] mux_sel;        // 0 half-sum, 1 and, 2 or, 3 shift input
    } alu_ctrl_t;

    // one control word, seen either as a command or as raw control bits
    typedef union packed {
        alu_cmd_e  cmd;
        alu_ctrl_t ctrl;
    } alu_ctrl_u;

endpackage

/* logic/alu_slice.sv */
`timescale 1ns/1ps

module alu_slice #(
    parameter int SLICE_W = alu_pkg::SLICE_W_DEF
) (
    input  logic [SLICE_W-1:0] a,
    input  logic [SLICE_W-1:0] b,
    input  alu_pkg::alu_ctrl_t ctrl,
    input  logic               carry_in,
    input  logic               shift_in,
    slice_result_if.producer   r
);

    logic [SLICE_W-1:0] gen;
    logic [SLICE_W-1:0] prop;
    logic [SLICE_W:0]   carry;
    logic [SLICE_W:0]   b_eff;  // top entry is the bit shifted in from above
    logic [SLICE_W-1:0] res;

    // carry into bit n, flattened into sum-of-products form
    // every generate term is ANDed with all the propagates above it
    function automatic logic lookahead(
        input logic [SLICE_W-1:0] g,
        input logic [SLICE_W-1:0] p,
        input logic               c0,
        input int                 n
    );
        logic any;
        logic term;

        any = 1'b0;
        for (int j = 0; j < n; j++) begin
            term = g[j];
            for (int k = j + 1; k < n; k++) begin
                term = term & p[k];
            end
            any = any | term;
        end
        term = c0;  // the slice carry in has to pass every propagate
        for (int k = 0; k < n; k++) begin
            term = term & p[k];
        end
        return any | term;
    endfunction

    assign carry[0]       = carry_in;
    assign b_eff[SLICE_W] = shift_in;

    for (genvar i = 0; i < SLICE_W; i++) begin : g_cell
        assign carry[i+1] = lookahead(gen, prop, carry_in, i + 1);

        bit_cell u_cell (
            .a_bit    (a[i]),
            .b_bit    (b[i]),
            .carry    (carry[i]),
            .shift_in (b_eff[i+1]),  // each cell takes its left neighbour for RSHFT
            .ctrl     (ctrl),
            .res      (res[i]),
            .gen      (gen[i]),
            .prop     (prop[i]),
            .b_eff    (b_eff[i])
        );
    end

    assign r.res       = res;
    assign r.carry_out = carry[SLICE_W];
    assign r.zero      = ~|res;
    assign r.all_ones  = &res;  // for COMP this means a equal to b within the slice

endmodule

/* logic/bit_cell.sv */
`timescale 1ns/1ps

module bit_cell (
    input  logic              a_bit,
    input  logic              b_bit,
    input  logic              carry,
    input  logic              shift_in,
    input  alu_pkg::alu_ctrl_t ctrl,
    output logic              res,
    output logic              gen,
    output logic              prop,
    output logic              b_eff
);

    logic mux_out;
    logic carry_gated;

    assign b_eff = b_bit ^ ctrl.b_inv;  // operand 2 as the adder sees it

    assign gen  = a_bit & b_eff;
    assign prop = a_bit | b_eff;  // or-type propagate, fine for lookahead since gen covers 1+1

    // the half-sum reuses gen and prop instead of a separate xor gate
    always_comb begin
        unique case (ctrl.mux_sel)
            2'b00:   mux_out = ~gen & prop;
            2'b01:   mux_out = gen;
            2'b10:   mux_out = prop;
            default: mux_out = shift_in;
        endcase
    end

    assign carry_gated = carry & ~ctrl.carry_disable;  // logic ops and shift ignore the carry

    assign res = mux_out ^ carry_gated;

endmodule

/* logic/carry_select_pair.sv */
`timescale 1ns/1ps

// the high half is built twice, so it never waits on the low carry
module carry_select_pair #(
    parameter int SLICE_W = alu_pkg::SLICE_W_DEF
) (
    input  logic [SLICE_W-1:0] a,
    input  logic [SLICE_W-1:0] b,
    input  alu_pkg::alu_ctrl_t ctrl,
    input  logic               shift_in,
    slice_result_if.producer   r0,
    slice_result_if.producer   r1
);

    // variant for a low carry of 0
    alu_slice #(
        .SLICE_W (SLICE_W)
    ) u_carry0 (
        .a        (a),
        .b        (b),
        .ctrl     (ctrl),
        .carry_in (1'b0),
        .shift_in (shift_in),
        .r        (r0)
    );

    // variant for a low carry of 1
    alu_slice #(
        .SLICE_W (SLICE_W)
    ) u_carry1 (
        .a        (a),
        .b        (b),
        .ctrl     (ctrl),
        .carry_in (1'b1),
        .shift_in (shift_in),  // same fill as u_carry0, so logic results agree
        .r        (r1)
    );

endmodule

/* logic/result_merge.sv */
`timescale 1ns/1ps

module result_merge #(
    parameter int SLICE_W = alu_pkg::SLICE_W_DEF
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       valid,
    input  logic                       carry_disable,
    slice_result_if.consumer           low,
    slice_result_if.consumer           hi0,
    slice_result_if.consumer           hi1,
    output logic                       out_valid,
    output logic [alu_pkg::DATA_W-1:0] result,
    output logic                       carry_out,
    output logic                       zero,
    output logic                       equal
);

    import alu_pkg::*;

    localparam int HI_W = DATA_W - SLICE_W;

    logic            sel_hi1;
    logic [HI_W-1:0] hi_res;
    logic            hi_carry;
    logic            hi_zero;
    logic            hi_all_ones;

    // the low carry picks the high half only for arithmetic
    assign sel_hi1 = ~carry_disable & low.carry_out;

    always_comb begin
        if (sel_hi1) begin
            hi_res      = hi1.res;
            hi_carry    = hi1.carry_out;
            hi_zero     = hi1.zero;
            hi_all_ones = hi1.all_ones;
        end else begin
            hi_res      = hi0.res;
            hi_carry    = hi0.carry_out;
            hi_zero     = hi0.zero;
            hi_all_ones = hi0.all_ones;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
            carry_out <= 1'b0;
            zero      <= 1'b0;
            equal     <= 1'b0;
        end else begin
            out_valid <= valid;
            if (valid) begin  // outputs hold between operations
                result    <= {hi_res, low.res};
                carry_out <= hi_carry & ~carry_disable;  // no carry reported for logic ops
                zero      <= low.zero & hi_zero;
                equal     <= low.all_ones & hi_all_ones;
            end
        end
    end

endmodule

/* logic/slice_result_if.sv */
`timescale 1ns/1ps

interface slice_result_if #(
    parameter int SLICE_W = alu_pkg::SLICE_W_DEF
);

    logic [SLICE_W-1:0] res;        // slice result bits
    logic               carry_out;  // carry out of the top bit
    logic               zero;       // res is all zeros
    logic               all_ones;   // res is all ones

    modport producer (
        output res, carry_out, zero, all_ones
    );

    modport consumer (
        input res, carry_out, zero, all_ones
    );

endinterface

/* sim/alu8_tb.sv */
`timescale 1ns/1ps

module alu8_tb;

    import alu_pkg::*;

    localparam int LAT_BURSTS = 4;
    localparam int LAT_CYCLES = LAT_BURSTS * 11;  // up to 8 ops and 3 idle cycles per burst
    localparam int ADDSUB_OPS = 72;
    localparam int LOGIC_OPS  = 80;
    localparam int COMP_OPS   = 40;
    localparam int SHIFT_OPS  = 40;
    localparam int ZERO_OPS   = 8;
    localparam int NUM_TESTS  = 6;
    localparam int BUDGET     = LAT_CYCLES + ADDSUB_OPS + LOGIC_OPS + COMP_OPS
                              + SHIFT_OPS + ZERO_OPS + 4 * NUM_TESTS;  // drain cycles per test

    typedef struct packed {
        alu_cmd_e   cmd;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] res;
        logic       cout;
        logic       zero;
        logic       equal;
    } exp_t;

    logic       clk;
    logic       arst_n;
    logic       in_valid;
    alu_ctrl_u  op;
    logic       carry_in;
    logic [7:0] a;
    logic [7:0] b;
    logic       out_valid;
    logic [7:0] result;
    logic       carry_out;
    logic       zero;
    logic       equal;

    exp_t exp_q[$];
    exp_t exp_cur;         // expectation for the result now on the outputs
    int   issued       = 0;
    int   checked      = 0;
    int   errors       = 0;
    int   test_errors  = 0;
    int   test_issued  = 0;

    alu8_top #(.SLICE_W(SLICE_W_DEF)) UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .op        (op),
        .carry_in  (carry_in),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result),
        .carry_out (carry_out),
        .zero      (zero),
        .equal     (equal)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reference rules for each command
    function automatic exp_t expected_for(input alu_cmd_e cmd, input logic cin,
                                          input logic [7:0] op_a, input logic [7:0] op_b);
        exp_t e;
        int   sum;

        e.cmd  = cmd;
        e.a    = op_a;
        e.b    = op_b;
        e.cout = 1'b0;  // logic ops and the shift never report a carry
        case (cmd)
            ADD: begin
                sum    = int'(op_a) + int'(op_b) + int'(cin);
                e.res  = sum[7:0];
                e.cout = sum > 255;
            end
            SUB: begin
                e.res  = op_a - op_b;
                e.cout = op_a >= op_b;
            end
            COMP: begin
                e.res  = op_a - op_b - 8'd1;
                e.cout = op_a > op_b;
            end
            XOR:     e.res = op_a ^ op_b;
            XNOR:    e.res = ~(op_a ^ op_b);
            AND:     e.res = op_a & op_b;
            OR:      e.res = op_a | op_b;
            RSHFT:   e.res = {cin, op_b[7:1]};
            default: e.res = 8'h00;
        endcase
        e.zero  = e.res == 8'h00;
        e.equal = (cmd == COMP) ? (op_a == op_b) : (e.res == 8'hFF);
        return e;
    endfunction

    function automatic logic [7:0] rand_byte();
        return 8'($urandom());
    endfunction

    function automatic void report_mismatch(input string what, input logic [7:0] want);
        $display("CHECK FAILED at %0t ns: %s wrong for %s a=%02h b=%02h, expected %02h",
                 $time, what, exp_cur.cmd.name(), exp_cur.a, exp_cur.b, want);
        errors++;
    endfunction

    task automatic issue_op(input alu_cmd_e cmd, input logic cin,
                            input logic [7:0] op_a, input logic [7:0] op_b);
        @(negedge clk);
        in_valid = 1'b1;
        op.cmd   = cmd;
        carry_in = cin;
        a        = op_a;
        b        = op_b;
        exp_q.push_back(expected_for(cmd, cin, op_a, op_b));
        issued++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    // waits until every queued result has been seen and checked
    task automatic finish_test(input string name);
        idle_cycles(1);
        while (exp_q.size() != 0) @(negedge clk);
        @(posedge clk);
        @(negedge clk);
        if (errors == test_errors) begin
            $display("test %-8s done: %0d ops, no errors", name, issued - test_issued);
        end else begin
            $display("test %-8s done: %0d ops, %0d errors", name, issued - test_issued,
                     errors - test_errors);
        end
        test_errors = errors;
        test_issued = issued;
    endtask

    // the queue head moves on mid-cycle, the assertions sample it at the next rising edge
    always @(negedge clk) begin
        if (arst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t ns: out_valid is high with no operation pending", $time);
                errors++;
            end else begin
                exp_cur = exp_q.pop_front();
                checked++;
            end
        end
    end

    latency_check: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid, 2))
        else begin
            $display("CHECK FAILED at %0t ns: out_valid does not follow in_valid by two edges",
                     $time);
            errors++;
        end

    result_check: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> result == exp_cur.res)
        else report_mismatch("result", exp_cur.res);

    carry_check: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> carry_out == exp_cur.cout)
        else report_mismatch("carry_out", 8'(exp_cur.cout));

    zero_check: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> zero == exp_cur.zero)
        else report_mismatch("zero", 8'(exp_cur.zero));

    equal_check: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> equal == exp_cur.equal)
        else report_mismatch("equal", 8'(exp_cur.equal));

    initial begin
        #((BUDGET + 20) * 40);
        $display("TIMEOUT: the run did not finish within %0d clock cycles", BUDGET + 20);
        $display("Regression failed");
        $finish;
    end

    initial begin
        logic [7:0] bounds [4];
        logic [7:0] x;
        logic [7:0] y;
        int         burst;
        int         gap;

        arst_n   = 1'b0;
        in_valid = 1'b0;
        op       = '0;
        carry_in = 1'b0;
        a        = 8'h00;
        b        = 8'h00;
        void'($urandom(32'he7fc93bf));
        bounds   = '{8'h00, 8'h0F, 8'hF0, 8'hFF};

        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (out_valid === 1'b0)
            else begin
                $display("CHECK FAILED at %0t ns: out_valid is high after reset", $time);
                errors++;
            end

        // back-to-back streams of random length with random gaps
        for (int k = 0; k < LAT_BURSTS; k++) begin
            burst = 1 + int'($urandom_range(7));
            gap   = int'($urandom_range(3));
            repeat (burst) issue_op(ADD, 1'b0, rand_byte(), rand_byte());
            idle_cycles(gap);
        end
        finish_test("latency");

        foreach (bounds[i]) begin
            foreach (bounds[j]) begin
                issue_op(ADD, 1'b0, bounds[i], bounds[j]);
                issue_op(SUB, 1'b1, bounds[i], bounds[j]);
            end
        end
        repeat (20) begin
            x = rand_byte();
            y = rand_byte();
            issue_op(ADD, 1'b0, x, y);
            issue_op(SUB, 1'b1, x, y);
        end
        finish_test("add_sub");

        repeat (20) begin
            issue_op(XOR, 1'($urandom()), rand_byte(), rand_byte());  // carry_in must not matter
            issue_op(XNOR, 1'($urandom()), rand_byte(), rand_byte());
            issue_op(AND, 1'($urandom()), rand_byte(), rand_byte());
            issue_op(OR, 1'($urandom()), rand_byte(), rand_byte());
        end
        finish_test("logic");

        repeat (20) begin
            x = rand_byte();
            issue_op(COMP, 1'b0, x, rand_byte());
            issue_op(COMP, 1'b0, x, x);
        end
        finish_test("comp");

        repeat (20) begin
            issue_op(RSHFT, 1'b0, rand_byte(), rand_byte());
            issue_op(RSHFT, 1'b1, rand_byte(), rand_byte());
        end
        finish_test("rshft");

        issue_op(ADD, 1'b0, 8'h00, 8'h00);
        issue_op(ADD, 1'b0, 8'h80, 8'h80);  // zero with a carry out
        issue_op(ADD, 1'b0, 8'h01, 8'hFF);
        issue_op(SUB, 1'b1, 8'h5A, 8'h5A);
        issue_op(SUB, 1'b1, 8'h00, 8'h00);
        issue_op(SUB, 1'b1, 8'hFF, 8'hFF);
        issue_op(AND, 1'b0, 8'hF0, 8'h0F);
        issue_op(AND, 1'b1, 8'h55, 8'hAA);
        finish_test("zero");

        $display("summary: %0d ops issued, %0d results checked, %0d errors",
                 issued, checked, errors);
        if (errors == 0 && checked == issued) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* src.f */
logic/alu_pkg.sv
logic/slice_result_if.sv
logic/bit_cell.sv
logic/alu_slice.sv
logic/carry_select_pair.sv
logic/result_merge.sv
logic/alu8_top.sv
sim/alu8_tb.sv
